/* ooo_consts.svh */
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

////////////////////////////////////////////////////////////
// machine sizes
////////////////////////////////////////////////////////////

`define ROB_DEPTH     8     // power of two, pointers wrap naturally
`define PRF_NUM       16
`define ARF_NUM       8

// PRF_NUM must cover ARF_NUM + ROB_DEPTH or the free list can run dry

////////////////////////////////////////////////////////////
// result network and unit timing
////////////////////////////////////////////////////////////

`define CDB_WIDTH     2     // lane 0 fast unit, lane 1 slow unit
`define SLOW_LATENCY  4     // cycles from issue to cdb strobe

`endif

/* ooo_types_pkg.sv */
`include "ooo_consts.svh"

package ooo_types_pkg;

    ////////////////////////////////////////////////////////////
    // index types, sized from the machine constants
    ////////////////////////////////////////////////////////////

    // rob slot, no wrap bit
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    typedef logic [$clog2(`PRF_NUM)-1:0]   prf_idx_t;   // physical register
    typedef logic [$clog2(`ARF_NUM)-1:0]   arf_idx_t;   // architectural register

    ////////////////////////////////////////////////////////////
    // data
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;

endpackage

/* rename_map.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rename_map
import ooo_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     disp_valid,
    input  arf_idx_t disp_rd,
    input  logic     rob_ready,
    input  logic     free_valid,
    input  prf_idx_t free_phy,
    output logic     disp_ready,
    output logic     alloc,
    output prf_idx_t alloc_phy,
    output arf_idx_t alloc_rd
);

    localparam int FL_DEPTH = `PRF_NUM - `ARF_NUM;
    localparam int FL_IDX   = $clog2(FL_DEPTH);

    prf_idx_t          spec_map [`ARF_NUM];    // speculative rat kept for source renaming
    prf_idx_t          fl_q     [FL_DEPTH];
    logic [FL_IDX-1:0] fl_head;
    logic [FL_IDX-1:0] fl_tail;
    logic [FL_IDX:0]   fl_count;
    logic              fl_empty;
    logic              fl_full;

    assign fl_empty   = (fl_count == '0);
    assign fl_full    = (fl_count == (FL_IDX+1)'(FL_DEPTH));

    assign disp_ready = rob_ready && !fl_empty;
    assign alloc      = disp_valid && disp_ready;
    assign alloc_phy  = fl_q[fl_head];          // head of free queue
    assign alloc_rd   = disp_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARF_NUM; i++) begin
                spec_map[i] <= prf_idx_t'(i);   // identity mapping
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_q[i] <= prf_idx_t'(`ARF_NUM + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;                     // queue starts full so the tail has wrapped
            fl_count <= (FL_IDX+1)'(FL_DEPTH);
        end else begin
            if (alloc) begin
                spec_map[alloc_rd] <= alloc_phy;
                fl_head <= (fl_head == FL_IDX'(FL_DEPTH-1)) ? '0 : fl_head + 1'b1;
            end
            if (free_valid) begin
                fl_q[fl_tail] <= free_phy;
                fl_tail <= (fl_tail == FL_IDX'(FL_DEPTH-1)) ? '0 : fl_tail + 1'b1;
            end
            case ({alloc, free_valid})
                2'b10:   fl_count <= fl_count - 1'b1;
                2'b01:   fl_count <= fl_count + 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    initial assert (`PRF_NUM >= `ARF_NUM + `ROB_DEPTH)
        else $fatal(1, "rename_map: PRF_NUM too small for ARF_NUM + ROB_DEPTH");

    assert property (@(posedge clk) disable iff (rst) free_valid |-> !fl_full)
        else $error("rename_map: push onto full free list");

    // a fresh register can never be the live speculative mapping
    assert property (@(posedge clk) disable iff (rst)
        alloc |-> (alloc_phy != spec_map[alloc_rd]))
        else $error("rename_map: allocated register still mapped");

endmodule

/* rob.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module rob
import ooo_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        alloc,
    input  prf_idx_t    alloc_phy,
    input  arf_idx_t    alloc_rd,
    input  logic        cdb_valid  [`CDB_WIDTH],
    input  rob_idx_t    cdb_rob_id [`CDB_WIDTH],
    input  word_t       cdb_value  [`CDB_WIDTH],
    output logic        rob_ready,
    output rob_idx_t    alloc_rob_id,
    output logic        commit_valid,
    output arf_idx_t    commit_rd,
    output prf_idx_t    commit_phy,
    output word_t       commit_value,
    output logic [31:0] commit_order
);

    localparam int IDX_W = $clog2(`ROB_DEPTH);
    localparam int PTR_W = IDX_W + 1;          // extra wrap bit

    logic             ready_q [`ROB_DEPTH];
    prf_idx_t         phy_q   [`ROB_DEPTH];
    arf_idx_t         rd_q    [`ROB_DEPTH];
    word_t            value_q [`ROB_DEPTH];

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [PTR_W-1:0] count;
    rob_idx_t         head_idx;
    rob_idx_t         tail_idx;
    logic             full;
    logic             empty;
    logic             pop;

    assign head_idx = head_ptr[IDX_W-1:0];
    assign tail_idx = tail_ptr[IDX_W-1:0];
    assign count    = tail_ptr - head_ptr;     // occupancy, wrap bit keeps full distinct
    assign full     = (count == PTR_W'(`ROB_DEPTH));
    assign empty    = (count == '0);
    assign pop      = !empty && ready_q[head_idx];

    assign rob_ready    = !full;
    assign alloc_rob_id = tail_idx;

    ////////////////////////////////////////////////////////////
    // pointers, ready bits, order counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ready_q[i] <= 1'b0;
            end
            head_ptr     <= '0;
            tail_ptr     <= '0;
            commit_order <= '0;
        end else begin
            if (alloc) begin
                ready_q[tail_idx] <= 1'b0;
                tail_ptr <= tail_ptr + 1'b1;
            end
            for (int k = 0; k < `CDB_WIDTH; k++) begin   // snoop cdb
                if (cdb_valid[k]) begin
                    ready_q[cdb_rob_id[k]] <= 1'b1;
                end
            end
            if (pop) begin
                head_ptr     <= head_ptr + 1'b1;
                commit_order <= commit_order + 1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            phy_q[tail_idx] <= alloc_phy;
            rd_q[tail_idx]  <= alloc_rd;
        end
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (cdb_valid[k]) begin
                value_q[cdb_rob_id[k]] <= cdb_value[k];
            end
        end
    end

    // head entry goes straight to commit
    assign commit_valid = pop;
    assign commit_rd    = rd_q[head_idx];
    assign commit_phy   = phy_q[head_idx];
    assign commit_value = value_q[head_idx];

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) alloc |-> !full)
        else $error("rob: alloc while full");

    for (genvar k = 0; k < `CDB_WIDTH; k++) begin : g_cdb_chk
        // lane must hit a slot between head and tail
        assert property (@(posedge clk) disable iff (rst)
            cdb_valid[k] |-> ({1'b0, rob_idx_t'(cdb_rob_id[k] - head_idx)} < count))
            else $error("rob: cdb lane %0d targets empty slot", k);
    end

endmodule

/* retire_map.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module retire_map
import ooo_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     commit_valid,
    input  arf_idx_t commit_rd,
    input  prf_idx_t commit_phy,
    output logic     free_valid,
    output prf_idx_t free_phy
);

    prf_idx_t rrat [`ARF_NUM];     // committed architectural map

    ////////////////////////////////////////////////////////////
    // old mapping is released as the new one commits
    ////////////////////////////////////////////////////////////

    assign free_valid = commit_valid;
    assign free_phy   = rrat[commit_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARF_NUM; i++) begin
                rrat[i] <= prf_idx_t'(i);
            end
        end else if (commit_valid) begin
            rrat[commit_rd] <= commit_phy;
        end
    end

    // rename hands out only free registers, so the two can never alias
    assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> (free_phy != commit_phy))
        else $error("retire_map: freed register equals committed register");

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
import ooo_types_pkg::*;
#(
    parameter int LATENCY = 1
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  rob_idx_t issue_rob_id,
    input  word_t    issue_a,
    input  word_t    issue_b,
    input  logic     issue_xor,
    output logic     cdb_valid,
    output rob_idx_t cdb_rob_id,
    output word_t    cdb_value
);

    logic     valid_q [LATENCY];
    rob_idx_t tag_q   [LATENCY];
    word_t    data_q  [LATENCY];
    word_t    result;

    assign result = issue_xor ? (issue_a ^ issue_b) : (issue_a + issue_b);

    ////////////////////////////////////////////////////////////
    // shift pipeline, stage 0 takes the fresh result
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LATENCY; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= issue;
            for (int i = 1; i < LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= issue_rob_id;
        data_q[0] <= result;
        for (int i = 1; i < LATENCY; i++) begin
            tag_q[i]  <= tag_q[i-1];
            data_q[i] <= data_q[i-1];
        end
    end

    // last stage drives the lane
    assign cdb_valid  = valid_q[LATENCY-1];
    assign cdb_rob_id = tag_q[LATENCY-1];
    assign cdb_value  = data_q[LATENCY-1];

endmodule

/* ooo_core_top.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core_top
import ooo_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        disp_valid,
    input  arf_idx_t    disp_rd,
    input  word_t       disp_a,
    input  word_t       disp_b,
    input  logic        disp_slow,
    input  logic        disp_xor,
    output logic        disp_ready,
    output logic        commit_valid,
    output arf_idx_t    commit_rd,
    output prf_idx_t    commit_phy,
    output word_t       commit_value,
    output logic [31:0] commit_order
);

    logic     alloc;
    prf_idx_t alloc_phy;
    arf_idx_t alloc_rd;
    rob_idx_t alloc_rob_id;
    logic     rob_ready;
    logic     free_valid;
    prf_idx_t free_phy;

    logic     cdb_valid  [`CDB_WIDTH];
    rob_idx_t cdb_rob_id [`CDB_WIDTH];
    word_t    cdb_value  [`CDB_WIDTH];

    rename_map rename_map_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_rd    (disp_rd),
        .rob_ready  (rob_ready),
        .free_valid (free_valid),
        .free_phy   (free_phy),
        .disp_ready (disp_ready),
        .alloc      (alloc),
        .alloc_phy  (alloc_phy),
        .alloc_rd   (alloc_rd)
    );

    rob rob_inst (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .alloc_phy    (alloc_phy),
        .alloc_rd     (alloc_rd),
        .cdb_valid    (cdb_valid),
        .cdb_rob_id   (cdb_rob_id),
        .cdb_value    (cdb_value),
        .rob_ready    (rob_ready),
        .alloc_rob_id (alloc_rob_id),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_phy   (commit_phy),
        .commit_value (commit_value),
        .commit_order (commit_order)
    );

    ////////////////////////////////////////////////////////////
    // execution, one cdb lane per unit
    ////////////////////////////////////////////////////////////

    exec_unit #(.LATENCY(1)) fast_unit (
        .clk          (clk),
        .rst          (rst),
        .issue        (alloc && !disp_slow),
        .issue_rob_id (alloc_rob_id),
        .issue_a      (disp_a),
        .issue_b      (disp_b),
        .issue_xor    (disp_xor),
        .cdb_valid    (cdb_valid[0]),
        .cdb_rob_id   (cdb_rob_id[0]),
        .cdb_value    (cdb_value[0])
    );

    exec_unit #(.LATENCY(`SLOW_LATENCY)) slow_unit (
        .clk          (clk),
        .rst          (rst),
        .issue        (alloc && disp_slow),
        .issue_rob_id (alloc_rob_id),
        .issue_a      (disp_a),
        .issue_b      (disp_b),
        .issue_xor    (disp_xor),
        .cdb_valid    (cdb_valid[1]),
        .cdb_rob_id   (cdb_rob_id[1]),
        .cdb_value    (cdb_value[1])
    );

    retire_map retire_map_inst (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_phy   (commit_phy),
        .free_valid   (free_valid),
        .free_phy     (free_phy)
    );

endmodule

/* tb_ooo_core.sv */
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo_core
import ooo_types_pkg::*;
();

    localparam int NUM_ATTEMPTS   = 600;
    localparam int TIMEOUT_CYCLES = NUM_ATTEMPTS * (`SLOW_LATENCY + 4);

    typedef struct packed {
        arf_idx_t    rd;
        prf_idx_t    phy;           // predicted from the model free list
        word_t       value;
        logic        slow;
        logic        into_empty;    // rob was empty when it was accepted
        logic [31:0] accept_cycle;
    } op_t;

    logic        clk;
    logic        rst;
    logic        disp_valid;
    arf_idx_t    disp_rd;
    word_t       disp_a;
    word_t       disp_b;
    logic        disp_slow;
    logic        disp_xor;
    logic        disp_ready;
    logic        commit_valid;
    arf_idx_t    commit_rd;
    prf_idx_t    commit_phy;
    word_t       commit_value;
    logic [31:0] commit_order;

    op_t         op_q [$];          // accepted and not yet committed
    prf_idx_t    free_q [$];
    prf_idx_t    model_map [`ARF_NUM];
    logic [31:0] rng;
    logic [31:0] cycle_count;
    logic [31:0] commit_count;
    int          errors;
    int          attempts;
    int          lat_checks;
    int          peak_inflight;
    logic        timed_out;
    logic        done;

    ooo_core_top ooo_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_rd      (disp_rd),
        .disp_a       (disp_a),
        .disp_b       (disp_b),
        .disp_slow    (disp_slow),
        .disp_xor     (disp_xor),
        .disp_ready   (disp_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_phy   (commit_phy),
        .commit_value (commit_value),
        .commit_order (commit_order)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // four phases of 60 attempts cycle through normal, slow burst, normal and sparse
    task automatic drive_next_op();
        int phase;
        int pct;
        phase = (attempts / 60) % 4;
        pct   = (phase == 1) ? 100 : (phase == 3) ? 20 : 70;
        rng = xorshift32(rng);
        disp_valid <= (rng % 100) < pct;
        disp_rd    <= arf_idx_t'(rng >> 8);
        disp_slow  <= (phase == 1) ? 1'b1 : rng[16];
        disp_xor   <= rng[20];
        rng = xorshift32(rng);
        disp_a <= rng;
        rng = xorshift32(rng);
        disp_b <= rng;
        attempts++;
    endtask

    ////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////

    task automatic check_commit();
        op_t exp;
        int  latency;
        int  min_lat;
        assert (op_q.size() > 0) else begin
            $display("unexpected commit with no operation in flight at time %0t", $time);
            errors++;
        end
        if (op_q.size() > 0) begin
            exp = op_q.pop_front();
            compare_value("commit_rd", 32'(commit_rd), 32'(exp.rd));
            compare_value("commit_value", commit_value, exp.value);
            compare_value("commit_phy", 32'(commit_phy), 32'(exp.phy));
            compare_value("commit_order", commit_order, commit_count);
            for (int i = 0; i < `ARF_NUM; i++) begin    // no alias with a committed mapping
                assert (model_map[i] != commit_phy) else begin
                    $display("FAIL %0t: commit_phy %0d still held by r%0d", $time, commit_phy, i);
                    errors++;
                end
            end
            latency = int'(cycle_count - exp.accept_cycle);
            min_lat = exp.slow ? `SLOW_LATENCY + 1 : 2;
            if (exp.into_empty) begin
                compare_value("commit latency", 32'(latency), 32'(min_lat));
                lat_checks++;
            end else begin
                assert (latency >= min_lat) else begin
                    $display("FAIL %0t: commit after %0d cycles, minimum %0d", $time, latency,
                             min_lat);
                    errors++;
                end
            end
            free_q.push_back(model_map[exp.rd]);    // previous mapping released
            model_map[exp.rd] = exp.phy;
            commit_count++;
        end
    endtask

    task automatic record_accept(input int inflight);
        op_t op;
        op.rd           = disp_rd;
        op.phy          = free_q.pop_front();
        op.value        = disp_xor ? (disp_a ^ disp_b) : (disp_a + disp_b);
        op.slow         = disp_slow;
        op.into_empty   = (inflight == 0);
        op.accept_cycle = cycle_count;
        op_q.push_back(op);
    endtask

    // runs at each rising edge and sees the values from before the edge
    task automatic run_cycle();
        int inflight;
        inflight = op_q.size();
        cycle_count++;
        compare_value("disp_ready", 32'(disp_ready),
                      32'(inflight < `ROB_DEPTH && free_q.size() > 0));
        if (inflight > peak_inflight) begin
            peak_inflight = inflight;
        end
        if (commit_valid) begin
            check_commit();
        end
        if (disp_valid && disp_ready) begin
            record_accept(inflight);
        end
        if (!disp_valid || disp_ready) begin       // a stalled op is held
            if (attempts < NUM_ATTEMPTS) begin
                drive_next_op();
            end else begin
                disp_valid <= 1'b0;
            end
        end
        if (attempts >= NUM_ATTEMPTS && !disp_valid && op_q.size() == 0) begin
            done = 1'b1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            timed_out = 1'b1;
            done      = 1'b1;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst        <= 1'b1;
        disp_valid <= 1'b0;
        disp_rd    <= '0;
        disp_a     <= '0;
        disp_b     <= '0;
        disp_slow  <= 1'b0;
        disp_xor   <= 1'b0;
        rng           = 32'hcf9e_9ba2;
        cycle_count   = '0;
        commit_count  = '0;
        errors        = 0;
        attempts      = 0;
        lat_checks    = 0;
        peak_inflight = 0;
        timed_out     = 1'b0;
        done          = 1'b0;
        for (int i = 0; i < `ARF_NUM; i++) begin
            model_map[i] = prf_idx_t'(i);
        end
        for (int i = `ARF_NUM; i < `PRF_NUM; i++) begin
            free_q.push_back(prf_idx_t'(i));
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare_value("disp_ready after reset", 32'(disp_ready), 32'd1);
        compare_value("commit_valid after reset", 32'(commit_valid), 32'd0);
        while (!done) begin
            run_cycle();
            @(posedge clk);
        end
        if (timed_out) begin
            $display("timeout: run stopped after %0d cycles with %0d operations in flight",
                     cycle_count, op_q.size());
        end
        assert (peak_inflight >= `SLOW_LATENCY + 1) else begin
            $display("the slow pipeline never filled, ROB occupancy peaked at %0d",
                     peak_inflight);
            errors++;
        end
        assert (lat_checks > 0) else begin
            $display("no operation met an empty ROB, latency went unchecked");
            errors++;
        end
        $display("errors: %0d, commits: %0d, latency checks: %0d, peak occupancy: %0d",
                 errors, commit_count, lat_checks, peak_inflight);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
ooo_types_pkg.sv
rename_map.sv
rob.sv
retire_map.sv
exec_unit.sv
ooo_core_top.sv
tb_ooo_core.sv

/* Makefile */
SRCS = ooo_consts.svh ooo_types_pkg.sv rename_map.sv rob.sv retire_map.sv \
       exec_unit.sv ooo_core_top.sv tb_ooo_core.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_ooo_core: $(SRCS) verilog.f
	verilator --binary --timing --assert --top-module tb_ooo_core -f verilog.f

run: obj_dir/Vtb_ooo_core
	./obj_dir/Vtb_ooo_core | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
